// ==== hdl/board_map_pkg.sv ====
// Board register map
package board_map_pkg;

    // ------------------------------------------------------------------------
    // address decode
    // ------------------------------------------------------------------------
    localparam int REG_ADDR_W = 16;             // word address, byte bits 17..2

    localparam logic [3:0] ADDR_MAIN   = 4'd0;  // block number in bits 15..12

    // offsets inside the main block, word-address bits 3..0
    localparam logic [3:0] REG_STATUS  = 4'd0;
    localparam logic [3:0] REG_WDOG    = 4'd3;  // watchdog period
    localparam logic [3:0] REG_VERSION = 4'd4;
    localparam logic [3:0] REG_TEMPSNS = 4'd5;  // temperature sensors
    localparam logic [3:0] REG_DIGIN   = 4'd10; // digital inputs

    // ------------------------------------------------------------------------
    // board identity
    // ------------------------------------------------------------------------
    localparam logic [3:0]  NUM_CHAN      = 4'd10;
    localparam logic [31:0] BOARD_VERSION = 32'h64524131;  // "dRA1"

    // status word bit positions, host software relies on these
    localparam int STATUS_RELAY_BIT      = 16;  // requested relay state
    localparam int STATUS_RELAY_MASK_BIT = 17;  // relay write enable
    localparam int STATUS_WDOG_BIT       = 23;  // watchdog timeout, write 1 clears

    // ------------------------------------------------------------------------
    // timing
    // ------------------------------------------------------------------------
    // sysclk cycles per watchdog period unit
    localparam int WDOG_TICK = 256;

    // 40 ms at 49.152 MHz before amps are let loose after mv_good
    localparam int MV_SETTLE_DEFAULT = 1966080;

endpackage

// ==== hdl/axil_pkg.sv ====
// AXI4-Lite bus definitions
package axil_pkg;

    // byte address, covers the 16-bit word space of the register file
    localparam int AXIL_ADDR_W = 18;
    localparam int AXIL_DATA_W = 32;

    // response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;

endpackage

// ==== hdl/axil_reg_bridge.sv ====
// AXI4-Lite to register file bridge
module axil_reg_bridge (
    input  logic                                 sysclk,
    input  logic                                 reset,

    // write address / data / response
    input  logic [axil_pkg::AXIL_ADDR_W-1:0]     s_axil_awaddr,
    input  logic                                 s_axil_awvalid,
    output logic                                 s_axil_awready,
    input  logic [axil_pkg::AXIL_DATA_W-1:0]     s_axil_wdata,
    input  logic [axil_pkg::AXIL_DATA_W/8-1:0]   s_axil_wstrb,
    input  logic                                 s_axil_wvalid,
    output logic                                 s_axil_wready,
    output logic [1:0]                           s_axil_bresp,
    output logic                                 s_axil_bvalid,
    input  logic                                 s_axil_bready,

    // read address / data
    input  logic [axil_pkg::AXIL_ADDR_W-1:0]     s_axil_araddr,
    input  logic                                 s_axil_arvalid,
    output logic                                 s_axil_arready,
    output logic [axil_pkg::AXIL_DATA_W-1:0]     s_axil_rdata,
    output logic [1:0]                           s_axil_rresp,
    output logic                                 s_axil_rvalid,
    input  logic                                 s_axil_rready,

    // register file side
    output logic [board_map_pkg::REG_ADDR_W-1:0] reg_raddr,
    output logic [board_map_pkg::REG_ADDR_W-1:0] reg_waddr,
    output logic [axil_pkg::AXIL_DATA_W-1:0]     reg_wdata,
    output logic                                 reg_wen,
    input  logic [axil_pkg::AXIL_DATA_W-1:0]     reg_rdata
);
    import axil_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,    // waiting for a request, grants raised from here
        ST_WRESP,   // write response held until bready
        ST_RWAIT,   // register file capturing read data
        ST_RRESP    // read response held until rready
    } state_t;

    state_t state;

    // ------------------------------------------------------------------------
    // transfer sequencing, one at a time, writes win
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (reset) begin
            state          <= ST_IDLE;
            s_axil_awready <= 1'b0;
            s_axil_wready  <= 1'b0;
            s_axil_arready <= 1'b0;
            s_axil_bvalid  <= 1'b0;
            s_axil_rvalid  <= 1'b0;
            reg_wen        <= 1'b0;
        end else begin
            reg_wen <= 1'b0;                            // single-cycle strobe
            case (state)
                ST_IDLE: begin
                    if (s_axil_awready) begin           // aw + w handshake now
                        s_axil_awready <= 1'b0;
                        s_axil_wready  <= 1'b0;
                        reg_wen        <= &s_axil_wstrb; // partial words dropped
                        s_axil_bvalid  <= 1'b1;
                        state          <= ST_WRESP;
                    end else if (s_axil_arready) begin  // ar handshake now
                        s_axil_arready <= 1'b0;
                        state          <= ST_RWAIT;
                    end else if (s_axil_awvalid && s_axil_wvalid) begin
                        s_axil_awready <= 1'b1;
                        s_axil_wready  <= 1'b1;
                    end else if (s_axil_arvalid) begin
                        s_axil_arready <= 1'b1;
                    end
                end
                ST_WRESP: begin
                    if (s_axil_bready) begin
                        s_axil_bvalid <= 1'b0;
                        state         <= ST_IDLE;
                    end
                end
                ST_RWAIT: begin
                    s_axil_rvalid <= 1'b1;              // reg_rdata lands this edge
                    state         <= ST_RRESP;
                end
                default: begin
                    if (s_axil_rready) begin
                        s_axil_rvalid <= 1'b0;
                        state         <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // address and data capture, byte to word address
    always_ff @(posedge sysclk) begin
        if (s_axil_awready) begin
            reg_waddr <= s_axil_awaddr[AXIL_ADDR_W-1:2];
            reg_wdata <= s_axil_wdata;
        end
        if (s_axil_arready)
            reg_raddr <= s_axil_araddr[AXIL_ADDR_W-1:2];  // held through response
    end

    assign s_axil_rdata = reg_rdata;  // decode lives in the register file
    assign s_axil_bresp = RESP_OKAY;
    assign s_axil_rresp = RESP_OKAY;

endmodule

// ==== hdl/input_sync.sv ====
// Two-flop pin synchronizer
module input_sync #(
    parameter type payload_t = logic
) (
    input  logic     sysclk,
    input  logic     reset,
    input  payload_t async_in,   // board-domain pins
    output payload_t sync_out
);

    payload_t meta;  // first stage, may go metastable

    always_ff @(posedge sysclk) begin
        if (reset) begin
            meta     <= '0;
            sync_out <= '0;
        end else begin
            meta     <= async_in;
            sync_out <= meta;
        end
    end

endmodule

// ==== hdl/board_regs.sv ====
// Board parameter registers
module board_regs #(
    parameter int MV_SETTLE = board_map_pkg::MV_SETTLE_DEFAULT  // cycles, scales with sysclk
) (
    input  logic                                 sysclk,
    input  logic                                 reset,

    // register file strobes
    input  logic [board_map_pkg::REG_ADDR_W-1:0] reg_raddr,
    input  logic [board_map_pkg::REG_ADDR_W-1:0] reg_waddr,
    input  logic [axil_pkg::AXIL_DATA_W-1:0]     reg_wdata,
    input  logic                                 reg_wen,
    output logic [axil_pkg::AXIL_DATA_W-1:0]     reg_rdata,

    // board state, already synchronous
    input  logic [3:0]                           board_id,    // rotary switch
    input  logic [31:0]                          dig_in,
    input  logic                                 mv_good,     // motor voltage good
    input  logic                                 relay,       // relay feedback
    input  logic                                 pwr_enable,
    input  logic                                 is_ecm,
    input  logic [31:0]                          temp_sense,
    input  logic [11:0]                          amp_status,

    output logic                                 relay_on,    // safety relay drive
    output logic                                 mv_amp_disable,
    output logic [15:0]                          wdog_period,
    output logic                                 wdog_clear,
    input  logic                                 wdog_timeout
);
    import board_map_pkg::*;

    localparam int CNT_W = $clog2(MV_SETTLE + 1);
    localparam logic [CNT_W-1:0] SETTLE_CNT = CNT_W'(MV_SETTLE);

    logic [31:0]      reg_status;
    logic             write_main;
    logic             read_main;
    logic [CNT_W-1:0] mv_cnt;     // cycles since mv_good came up

    // channel count and board id on top, amp feedback at the bottom
    assign reg_status = {NUM_CHAN, board_id,
                         wdog_timeout, is_ecm, 2'b00,
                         mv_good, pwr_enable, ~relay, relay_on,
                         4'b0000,
                         amp_status};

    // main block only, bits 7..4 must be clear
    assign write_main = reg_wen && (reg_waddr[15:12] == ADDR_MAIN) && (reg_waddr[7:4] == 4'd0);
    assign read_main  = (reg_raddr[15:12] == ADDR_MAIN) && (reg_raddr[7:4] == 4'd0);

    // ------------------------------------------------------------------------
    // host writes
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (reset) begin
            relay_on    <= 1'b0;
            wdog_period <= 16'd0;   // watchdog off
            wdog_clear  <= 1'b0;
        end else begin
            wdog_clear <= write_main && (reg_waddr[3:0] == REG_STATUS)
                          && reg_wdata[STATUS_WDOG_BIT];
            if (wdog_timeout)
                relay_on <= 1'b0;   // timeout opens the safety loop
            else if (write_main && (reg_waddr[3:0] == REG_STATUS)
                     && reg_wdata[STATUS_RELAY_MASK_BIT])
                relay_on <= reg_wdata[STATUS_RELAY_BIT];
            if (write_main && (reg_waddr[3:0] == REG_WDOG))
                wdog_period <= reg_wdata[15:0];
        end
    end

    // read data, captured on any non-write cycle
    always_ff @(posedge sysclk) begin
        if (!reg_wen) begin
            if (!read_main)
                reg_rdata <= '0;
            else
                case (reg_raddr[3:0])
                    REG_STATUS:  reg_rdata <= reg_status;
                    REG_WDOG:    reg_rdata <= {16'd0, wdog_period};
                    REG_VERSION: reg_rdata <= BOARD_VERSION;
                    REG_TEMPSNS: reg_rdata <= temp_sense;
                    REG_DIGIN:   reg_rdata <= dig_in;
                    default:     reg_rdata <= '0;
                endcase
        end
    end

    // ------------------------------------------------------------------------
    // motor voltage settle, amps held off until supply is steady
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (reset || !mv_good) begin
            mv_cnt         <= '0;
            mv_amp_disable <= 1'b1;
        end else if (mv_cnt < SETTLE_CNT) begin
            mv_cnt         <= mv_cnt + 1'b1;
            mv_amp_disable <= 1'b1;
        end else begin
            mv_amp_disable <= 1'b0;   // counter parks at limit
        end
    end

endmodule

// ==== hdl/wdog_timer.sv ====
// Host activity watchdog
module wdog_timer (
    input  logic        sysclk,
    input  logic        reset,
    input  logic [15:0] wdog_period,   // units of WDOG_TICK cycles, 0 = off
    input  logic        kick,          // any host write
    input  logic        wdog_clear,
    output logic        wdog_timeout
);
    import board_map_pkg::*;

    localparam int CNT_W = 16 + $clog2(WDOG_TICK);

    logic [CNT_W-1:0] cnt;     // cycles since last kick
    logic [CNT_W-1:0] limit;
    logic             expired;

    assign limit = CNT_W'(wdog_period) * CNT_W'(WDOG_TICK);

    // a kick on the same cycle still counts as activity
    assign expired = (wdog_period != 16'd0) && (cnt >= limit) && !kick;

    // ------------------------------------------------------------------------
    // idle counter
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (reset) begin
            cnt <= '0;
        end else if (kick || (wdog_period == 16'd0)) begin
            cnt <= '0;                  // restart, or parked when disabled
        end else if (cnt < limit) begin
            cnt <= cnt + 1'b1;          // saturates at the limit
        end
    end

    // sticky flag, only the host clears it
    always_ff @(posedge sysclk) begin
        if (reset || wdog_clear)
            wdog_timeout <= 1'b0;
        else if (expired)
            wdog_timeout <= 1'b1;
    end

endmodule

// ==== hdl/board_ctrl_top.sv ====
// Board controller top level
module board_ctrl_top #(
    parameter int MV_SETTLE = board_map_pkg::MV_SETTLE_DEFAULT
) (
    input  logic                               sysclk,
    input  logic                               reset,

    // AXI4-Lite slave
    input  logic [axil_pkg::AXIL_ADDR_W-1:0]   s_axil_awaddr,
    input  logic                               s_axil_awvalid,
    output logic                               s_axil_awready,
    input  logic [axil_pkg::AXIL_DATA_W-1:0]   s_axil_wdata,
    input  logic [axil_pkg::AXIL_DATA_W/8-1:0] s_axil_wstrb,
    input  logic                               s_axil_wvalid,
    output logic                               s_axil_wready,
    output logic [1:0]                         s_axil_bresp,
    output logic                               s_axil_bvalid,
    input  logic                               s_axil_bready,
    input  logic [axil_pkg::AXIL_ADDR_W-1:0]   s_axil_araddr,
    input  logic                               s_axil_arvalid,
    output logic                               s_axil_arready,
    output logic [axil_pkg::AXIL_DATA_W-1:0]   s_axil_rdata,
    output logic [1:0]                         s_axil_rresp,
    output logic                               s_axil_rvalid,
    input  logic                               s_axil_rready,

    // board pins
    input  logic [3:0]                         board_id,
    input  logic [31:0]                        dig_in,
    input  logic                               mv_good,
    input  logic                               relay,
    input  logic                               safety_fb,
    input  logic                               pwr_enable,
    input  logic                               is_ecm,
    input  logic [31:0]                        temp_sense,   // from serial reader
    input  logic [11:0]                        amp_status,   // from serial reader

    output logic                               relay_on,
    output logic                               mv_amp_disable,
    output logic                               wdog_timeout
);
    import axil_pkg::*;
    import board_map_pkg::*;

    logic [REG_ADDR_W-1:0]  reg_raddr, reg_waddr;
    logic [AXIL_DATA_W-1:0] reg_wdata, reg_rdata;
    logic                   reg_wen;      // also the watchdog kick
    logic [3:0]             board_id_s;
    logic [31:0]            dig_in_s;
    logic [2:0]             flags_s;      // safety_fb, relay, mv_good
    logic [15:0]            wdog_period;
    logic                   wdog_clear;

    axil_reg_bridge bridge_i (.*);

    // ------------------------------------------------------------------------
    // slow board pins
    // ------------------------------------------------------------------------
    input_sync #(.payload_t(logic [3:0])) id_sync_i (
        .sysclk, .reset, .async_in(board_id), .sync_out(board_id_s));
    input_sync #(.payload_t(logic [31:0])) din_sync_i (
        .sysclk, .reset, .async_in(dig_in), .sync_out(dig_in_s));
    input_sync #(.payload_t(logic [2:0])) flag_sync_i (
        .sysclk, .reset, .async_in({safety_fb, relay, mv_good}), .sync_out(flags_s));

    board_regs #(.MV_SETTLE(MV_SETTLE)) regs_i (
        .sysclk, .reset, .reg_raddr, .reg_waddr, .reg_wdata, .reg_wen, .reg_rdata,
        .board_id(board_id_s), .dig_in(dig_in_s), .mv_good(flags_s[0]),
        .relay(flags_s[1]), .pwr_enable, .is_ecm, .temp_sense, .amp_status,
        .relay_on, .mv_amp_disable, .wdog_period, .wdog_clear, .wdog_timeout);

    wdog_timer wdog_i (
        .sysclk, .reset, .wdog_period, .kick(reg_wen), .wdog_clear, .wdog_timeout);

endmodule

// ==== tb/board_ctrl_tb.sv ====
// Board controller testbench
module board_ctrl_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import axil_pkg::*;
    import board_map_pkg::*;

    logic                     sysclk = 1'b0;
    logic                     reset;
    logic [AXIL_ADDR_W-1:0]   s_axil_awaddr, s_axil_araddr;
    logic [AXIL_DATA_W-1:0]   s_axil_wdata, s_axil_rdata;
    logic [AXIL_DATA_W/8-1:0] s_axil_wstrb;
    logic [1:0]               s_axil_bresp, s_axil_rresp;
    logic                     s_axil_awvalid, s_axil_awready, s_axil_wvalid, s_axil_wready;
    logic                     s_axil_bvalid, s_axil_bready, s_axil_arvalid, s_axil_arready;
    logic                     s_axil_rvalid, s_axil_rready;
    logic [3:0]               board_id;
    logic [31:0]              dig_in, temp_sense;
    logic                     mv_good, relay, safety_fb, pwr_enable, is_ecm;
    logic [11:0]              amp_status;
    logic                     relay_on, mv_amp_disable, wdog_timeout;

    string  lines[$];               // command lines of the data file
    int     limit_cycles = 0;       // hang limit in cycles from the file
    integer seed = 32'hd817c2ce;

    always #4 sysclk = ~sysclk;     // 8 ns period

    board_ctrl_top #(.MV_SETTLE(200)) board_ctrl_top_i (.*);

    // ------------------------------------------------------------------------
    // reporting
    // ------------------------------------------------------------------------
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] expected,
                         input string what);
        if (got !== expected)
            abort_run($sformatf("MISMATCH at %0t ns: %s got %h, expected %h",
                                $time, what, got, expected));
    endtask

    // ------------------------------------------------------------------------
    // AXI4-Lite master
    // ------------------------------------------------------------------------
    // every call starts and ends on a falling edge
    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [31:0] stall);
        s_axil_awaddr  = addr[AXIL_ADDR_W-1:0];
        s_axil_wdata   = data;
        s_axil_awvalid = 1'b1;
        s_axil_wvalid  = 1'b1;
        @(negedge sysclk);
        while (!s_axil_awready)
            @(negedge sysclk);
        check({31'd0, s_axil_wready}, 32'd1, "wready together with awready");
        @(negedge sysclk);                  // aw/w handshake edge passed
        s_axil_awvalid = 1'b0;
        s_axil_wvalid  = 1'b0;
        while (!s_axil_bvalid)
            @(negedge sysclk);
        repeat (stall) begin                // hold off bready
            @(negedge sysclk);
            check({31'd0, s_axil_bvalid}, 32'd1, "bvalid held under back-pressure");
        end
        check({30'd0, s_axil_bresp}, {30'd0, RESP_OKAY}, "write response");
        s_axil_bready = 1'b1;
        @(negedge sysclk);
        s_axil_bready = 1'b0;
    endtask

    task automatic axi_read(input logic [31:0] addr, input logic [31:0] expected,
                            input logic [31:0] stall);
        s_axil_araddr  = addr[AXIL_ADDR_W-1:0];
        s_axil_arvalid = 1'b1;
        @(negedge sysclk);
        while (!s_axil_arready)
            @(negedge sysclk);
        @(negedge sysclk);                  // ar handshake edge passed
        s_axil_arvalid = 1'b0;
        while (!s_axil_rvalid)
            @(negedge sysclk);
        repeat (stall) begin                // rvalid must be held meanwhile
            @(negedge sysclk);
            check({31'd0, s_axil_rvalid}, 32'd1, "rvalid held under back-pressure");
        end
        check(s_axil_rdata, expected, $sformatf("read data at %h", addr));
        check({30'd0, s_axil_rresp}, {30'd0, RESP_OKAY}, "read response");
        s_axil_rready = 1'b1;
        @(negedge sysclk);
        s_axil_rready = 1'b0;
    endtask

    task automatic compare_output(input string name, input logic value);
        case (name)
            "relay_on":       check({31'd0, relay_on}, {31'd0, value}, name);
            "mv_amp_disable": check({31'd0, mv_amp_disable}, {31'd0, value}, name);
            "wdog_timeout":   check({31'd0, wdog_timeout}, {31'd0, value}, name);
            default:          abort_run($sformatf("unknown output name in test file: %s", name));
        endcase
    endtask

    // ------------------------------------------------------------------------
    // data file
    // ------------------------------------------------------------------------
    task automatic load_tests();
        int          fd;
        int          n;
        int          total;
        string       line;
        string       cmd;
        logic [31:0] cycles;
        total = 16;                         // reset and start-up margin
        fd = $fopen("tb/board_ctrl_tests.txt", "r");
        if (fd == 0)
            abort_run("could not open the test file tb/board_ctrl_tests.txt");
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line[0] != "#" && line[0] != "\n") begin
                lines.push_back(line);
                total += 64;                // budget per command
                n = $sscanf(line, "%s %d", cmd, cycles);
                if (cmd == "D")
                    total += int'(cycles);
            end
        end
        $fclose(fd);
        limit_cycles = total;
    endtask

    task automatic run_line(input string line);
        string       cmd;
        string       name;
        logic [31:0] a1, a2, a3, a4, a5, a6, a7;
        int          n;
        n = $sscanf(line, "%s", cmd);
        case (cmd)
            "W": begin
                n = $sscanf(line, "%s %h %h %d", cmd, a1, a2, a3);
                axi_write(a1, a2, (n > 3) ? a3 : 32'd0);
            end
            "R": begin
                n = $sscanf(line, "%s %h %h %d", cmd, a1, a2, a3);
                axi_read(a1, a2, (n > 3) ? a3 : 32'd0);
            end
            "P": begin
                n = $sscanf(line, "%s %h %h %h %h %h %h %h", cmd, a1, a2, a3, a4, a5, a6, a7);
                board_id   = a1[3:0];
                dig_in     = a2;
                mv_good    = a3[0];
                relay      = a4[0];
                pwr_enable = a5[0];
                is_ecm     = a6[0];
                amp_status = a7[11:0];
                repeat (4) @(negedge sysclk);   // through the synchronizers
            end
            "C": begin
                n = $sscanf(line, "%s %s %h", cmd, name, a1);
                compare_output(name, a1[0]);
            end
            "D": begin
                n = $sscanf(line, "%s %d", cmd, a1);
                repeat (a1) @(negedge sysclk);
            end
            "T": begin
                a1 = $random(seed);
                temp_sense = a1;                // serial reader value needs no sync
                axi_read({ADDR_MAIN, 8'h00, REG_TEMPSNS, 2'b00}, a1, 32'd0);
            end
            default: abort_run($sformatf("unknown command in test file: %s", line));
        endcase
    endtask

    // ------------------------------------------------------------------------
    // main sequence and hang guard
    // ------------------------------------------------------------------------
    initial begin
        reset          = 1'b1;
        s_axil_awaddr  = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wstrb   = '1;                // full words only
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b0;
        s_axil_araddr  = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b0;
        board_id       = 4'd0;
        dig_in         = 32'd0;
        mv_good        = 1'b0;
        relay          = 1'b0;
        safety_fb      = 1'b0;
        pwr_enable     = 1'b0;
        is_ecm         = 1'b0;
        temp_sense     = 32'd0;
        amp_status     = 12'd0;
        load_tests();
        repeat (2) @(negedge sysclk);
        reset = 1'b0;
        foreach (lines[i])
            run_line(lines[i]);
        $display("** PASS **");
        $finish;
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge sysclk);
        abort_run($sformatf("run hung, no finish after %0d cycles", limit_cycles));
    end

endmodule

// ==== tb/board_ctrl_tests.txt ====
# W addr data [stall] | R addr expect [stall] | P id dig mv relay pwr ecm amp
# C name value | D cycles | T = random temp_sense read back; hex except stall, D
R 00010 64524131
R 00004 00000000
R 04010 00000000
R 00050 00000000
C mv_amp_disable 1
P 5 a5a55a5a 0 1 1 0 abc
R 00000 a5040abc
R 00028 a5a55a5a
P 9 12345678 0 0 0 1 123
R 00000 a9420123
R 00028 12345678
W 00000 00030000
C relay_on 1
R 00000 a9430123
W 00000 00000000
C relay_on 1
W 00000 00020000
C relay_on 0
P 9 12345678 1 0 0 1 123
D 196
C mv_amp_disable 1
D 10
C mv_amp_disable 0
R 00000 a94a0123
P 9 12345678 0 0 0 1 123
C mv_amp_disable 1
W 00000 00030000
W 0000c 00000001
D 250
C wdog_timeout 0
D 20
C wdog_timeout 1
C relay_on 0
R 00000 a9c20123
R 0000c 00000001
W 00000 00800000
D 2
C wdog_timeout 0
W 0000c 00000000
T
W 00000 00030000 5
R 00000 a9430123 6
W 0000c 00000007 4
R 0000c 00000007 3
T

// ==== project.f ====
hdl/board_map_pkg.sv
hdl/axil_pkg.sv
hdl/axil_reg_bridge.sv
hdl/input_sync.sv
hdl/board_regs.sv
hdl/wdog_timer.sv
hdl/board_ctrl_top.sv
tb/board_ctrl_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the board controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

TOP=board_ctrl_tb
LOG=sim.log
FAIL_TEXT='** FAIL **'

verilator --binary --timing -Wno-fatal --top-module "$TOP" -f project.f -o "sim_$TOP"
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/"sim_$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -qF "$FAIL_TEXT" "$LOG"; then
    echo "simulation failed, see $LOG"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

echo "simulation passed"
exit 0
